/* hw/l2c_pkg.sv */
// ------------------------------------------------
// shared types and geometry of the FIFO initializer
// geometry is fixed at 32 FIFOs per kind and 10 depthwise channels
// ------------------------------------------------
package l2c_pkg;

    // layer opcodes, encodings fixed by the tile scheduler
    typedef enum logic [1:0] {
        POINTWISE = 2'd0,
        DEPTHWISE = 2'd1,
        STANDARD  = 2'd2,
        LINEAR    = 2'd3
    } layer_type_e;

    localparam int unsigned ADDR_W = 32;   // global buffer byte address

    typedef logic [ADDR_W-1:0] addr_t;

    // FIFOs of each kind: ifmap, ipsum, opsum
    localparam int unsigned FIFO_PER_KIND = 32;

    // depthwise pass geometry
    localparam int unsigned DW_CHANNELS = 10;  // input channels per pass
    localparam int unsigned KERNEL_TAPS = 3;   // kernel rows per channel

    // psum entries written in depthwise and standard modes
    localparam int unsigned PSUM_ROWS = 10;

    localparam int unsigned PSUM_BYTES = 2;    // one 16-bit partial sum

    // reads from here return zeros, used for the top pad row
    localparam addr_t ZERO_ZONE = 32'h8000_0000;

    localparam int unsigned CH_W = 8;          // in_c / out_c width

endpackage

/* hw/ifmap_addr_gen.sv */
// ------------------------------------------------
// ifmap FIFO base-address table, loaded on each clock with load_i high
// only the top pad row is handled; left, right and bottom pads are not
// ------------------------------------------------
module ifmap_addr_gen import l2c_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_i,
    input  layer_type_e       layer_type_i,
    input  addr_t             base_i,
    input  addr_t             tile_n_i,
    input  logic [CH_W-1:0]   in_c_i,
    input  addr_t             output_row_i,
    input  logic              tile_first_i,
    output addr_t             addr_o [FIFO_PER_KIND]
);

    typedef enum logic [2:0] {
        MODE_HOLD,
        MODE_PW,     // pointwise, one FIFO per tile column block
        MODE_PAD,    // first tile row 0, tap 0 reads the zero zone
        MODE_ALIGN,  // taps start on real rows
        MODE_SLIDE   // later rows, advance by one pixel
    } mode_e;

    mode_e mode;
    logic  row_is_0;
    logic  row_is_1;
    addr_t in_c;
    addr_t ch_stride;                     // bytes between two channels' rows
    addr_t chan_base [DW_CHANNELS];
    addr_t addr_d    [FIFO_PER_KIND];

    assign row_is_0  = (output_row_i == addr_t'(0));
    assign row_is_1  = (output_row_i == addr_t'(1));
    assign in_c      = addr_t'(in_c_i);
    assign ch_stride = tile_n_i * in_c;

    always_comb begin
        mode = MODE_HOLD;
        case (layer_type_i)
            POINTWISE: begin
                mode = MODE_PW;
            end
            DEPTHWISE: begin
                if (tile_first_i && row_is_0) begin
                    mode = MODE_PAD;
                end else if ((tile_first_i && row_is_1) || (!tile_first_i && row_is_0)) begin
                    mode = MODE_ALIGN;
                end else begin
                    mode = MODE_SLIDE;
                end
            end
            default: begin
                mode = MODE_HOLD;  // standard and linear leave the table alone
            end
        endcase
    end

    always_comb begin
        for (int c = 0; c < DW_CHANNELS; c++) begin
            chan_base[c] = base_i + addr_t'(c) * ch_stride;
        end
    end

    always_comb begin
        addr_d = addr_o;
        case (mode)
            MODE_PW: begin
                for (int i = 0; i < FIFO_PER_KIND; i++) begin
                    addr_d[i] = base_i + addr_t'(i) * tile_n_i;
                end
            end
            MODE_PAD: begin
                // taps shift down one row, the first reads padding
                for (int c = 0; c < DW_CHANNELS; c++) begin
                    addr_d[c*KERNEL_TAPS] = ZERO_ZONE;
                    for (int t = 1; t < KERNEL_TAPS; t++) begin
                        addr_d[c*KERNEL_TAPS + t] = chan_base[c] + addr_t'(t - 1) * in_c;
                    end
                end
            end
            MODE_ALIGN: begin
                for (int c = 0; c < DW_CHANNELS; c++) begin
                    for (int t = 0; t < KERNEL_TAPS; t++) begin
                        addr_d[c*KERNEL_TAPS + t] = chan_base[c] + addr_t'(t) * in_c;
                    end
                end
            end
            MODE_SLIDE: begin
                // zero-zone taps advance as well, entries past the taps hold
                for (int i = 0; i < DW_CHANNELS * KERNEL_TAPS; i++) begin
                    addr_d[i] = addr_o[i] + in_c;
                end
            end
            default: begin
                addr_d = addr_o;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FIFO_PER_KIND; i++) begin
                addr_o[i] <= '0;
            end
        end else if (load_i) begin
            addr_o <= addr_d;
        end
    end

endmodule

/* hw/psum_addr_gen.sv */
// ------------------------------------------------
// partial-sum FIFO base-address table, one copy each for ipsum and opsum
// spatial layers only write the first PSUM_ROWS entries
// ------------------------------------------------
module psum_addr_gen import l2c_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_i,
    input  layer_type_e       layer_type_i,
    input  addr_t             base_i,
    input  addr_t             on_real_i,
    input  logic [CH_W-1:0]   out_c_i,
    input  addr_t             output_row_i,
    output addr_t             addr_o [FIFO_PER_KIND]
);

    addr_t out_c;
    addr_t pw_stride;      // pointwise, one output block per FIFO
    addr_t sp_stride;      // spatial, one output row per FIFO
    addr_t row_off;        // current output row inside the tile
    addr_t addr_d [FIFO_PER_KIND];

    assign out_c     = addr_t'(out_c_i);
    assign pw_stride = on_real_i * addr_t'(PSUM_BYTES);
    assign sp_stride = on_real_i * out_c * addr_t'(PSUM_BYTES);
    assign row_off   = output_row_i * out_c * addr_t'(PSUM_BYTES);

    always_comb begin
        addr_d = addr_o;
        case (layer_type_i)
            POINTWISE: begin
                for (int i = 0; i < FIFO_PER_KIND; i++) begin
                    addr_d[i] = base_i + addr_t'(i) * pw_stride;
                end
            end
            DEPTHWISE, STANDARD: begin
                for (int i = 0; i < PSUM_ROWS; i++) begin
                    addr_d[i] = base_i + row_off + addr_t'(i) * sp_stride;
                end
            end
            default: begin
                addr_d = addr_o;  // linear layers keep the table
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FIFO_PER_KIND; i++) begin
                addr_o[i] <= '0;
            end
        end else if (load_i) begin
            addr_o <= addr_d;
        end
    end

endmodule

/* hw/l2c_init_fifo_pe.sv */
// ------------------------------------------------
// start-of-pass FIFO initializer, no handshake
// every edge with init_i high reloads the tables, valid one cycle later
// ------------------------------------------------
module l2c_init_fifo_pe import l2c_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              init_i,         // level, held for the init state
    input  layer_type_e       layer_type_i,
    input  addr_t             ifmap_base_i,
    input  addr_t             ipsum_base_i,
    input  addr_t             opsum_base_i,
    input  addr_t             tile_n_i,
    input  addr_t             on_real_i,
    input  logic [CH_W-1:0]   in_c_i,
    input  logic [CH_W-1:0]   out_c_i,
    input  addr_t             output_row_i,
    input  logic              tile_first_i,
    output addr_t             ifmap_addr_o [FIFO_PER_KIND],
    output addr_t             ipsum_addr_o [FIFO_PER_KIND],
    output addr_t             opsum_addr_o [FIFO_PER_KIND],
    output logic              ifmap_fifo_reset_o,
    output logic              ipsum_fifo_reset_o,
    output logic              opsum_fifo_reset_o
);

    // all FIFOs are flushed for as long as init is held
    assign ifmap_fifo_reset_o = init_i;
    assign ipsum_fifo_reset_o = init_i;
    assign opsum_fifo_reset_o = init_i;

    ifmap_addr_gen u_ifmap (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (init_i),
        .layer_type_i (layer_type_i),
        .base_i       (ifmap_base_i),
        .tile_n_i     (tile_n_i),
        .in_c_i       (in_c_i),
        .output_row_i (output_row_i),
        .tile_first_i (tile_first_i),
        .addr_o       (ifmap_addr_o)
    );

    // ipsum and opsum follow the same rules on different bases
    psum_addr_gen u_ipsum (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (init_i),
        .layer_type_i (layer_type_i),
        .base_i       (ipsum_base_i),
        .on_real_i    (on_real_i),
        .out_c_i      (out_c_i),
        .output_row_i (output_row_i),
        .addr_o       (ipsum_addr_o)
    );

    psum_addr_gen u_opsum (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (init_i),
        .layer_type_i (layer_type_i),
        .base_i       (opsum_base_i),
        .on_real_i    (on_real_i),
        .out_c_i      (out_c_i),
        .output_row_i (output_row_i),
        .addr_o       (opsum_addr_o)
    );

endmodule

/* test/l2c_init_checker.sv */
// ------------------------------------------------
// bound to the top, recomputes every table entry from the sampled inputs
// fail_cnt is read by the testbench
// ------------------------------------------------
module l2c_init_checker import l2c_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              init_i,
    input  layer_type_e       layer_type_i,
    input  addr_t             ifmap_base_i,
    input  addr_t             ipsum_base_i,
    input  addr_t             opsum_base_i,
    input  addr_t             tile_n_i,
    input  addr_t             on_real_i,
    input  logic [CH_W-1:0]   in_c_i,
    input  logic [CH_W-1:0]   out_c_i,
    input  addr_t             output_row_i,
    input  logic              tile_first_i,
    input  addr_t             ifmap_addr_i [FIFO_PER_KIND],
    input  addr_t             ipsum_addr_i [FIFO_PER_KIND],
    input  addr_t             opsum_addr_i [FIFO_PER_KIND],
    input  logic              ifmap_fifo_reset_i,
    input  logic              ipsum_fifo_reset_i,
    input  logic              opsum_fifo_reset_i
);

    int unsigned fail_cnt = 0;

    function automatic addr_t ifmap_rule(
        input int              i,
        input layer_type_e     lt,
        input addr_t           base,
        input addr_t           tile_n,
        input logic [CH_W-1:0] in_c,
        input addr_t           row,
        input logic            first,
        input addr_t           prev
    );
        int    c;
        int    t;
        addr_t ic;
        addr_t chan;
        addr_t exp;
        c    = i / int'(KERNEL_TAPS);
        t    = i % int'(KERNEL_TAPS);
        ic   = addr_t'(in_c);
        chan = base + addr_t'(c) * tile_n * ic;   // start of channel c
        exp  = prev;
        if (lt == POINTWISE) begin
            exp = base + addr_t'(i) * tile_n;
        end else if (lt == DEPTHWISE && i < int'(DW_CHANNELS * KERNEL_TAPS)) begin
            if (first && row == '0) begin
                exp = (t == 0) ? ZERO_ZONE : chan + addr_t'(t - 1) * ic;
            end else if ((first && row == 32'd1) || (!first && row == '0)) begin
                exp = chan + addr_t'(t) * ic;
            end else begin
                exp = prev + ic;   // slide by one pixel
            end
        end
        return exp;
    endfunction

    function automatic addr_t psum_rule(
        input int              i,
        input layer_type_e     lt,
        input addr_t           base,
        input addr_t           on_real,
        input logic [CH_W-1:0] out_c,
        input addr_t           row,
        input addr_t           prev
    );
        addr_t oc;
        addr_t exp;
        oc  = addr_t'(out_c);
        exp = prev;
        if (lt == POINTWISE) begin
            exp = base + addr_t'(PSUM_BYTES) * on_real * addr_t'(i);
        end else if ((lt == DEPTHWISE || lt == STANDARD) && i < int'(PSUM_ROWS)) begin
            // row offset plus one output row of out_c sums per entry
            exp = base + addr_t'(PSUM_BYTES) * oc * (row + addr_t'(i) * on_real);
        end
        return exp;
    endfunction

    a_resets_follow_init: assert property (@(posedge clk)
        ifmap_fifo_reset_i == init_i && ipsum_fifo_reset_i == init_i
        && opsum_fifo_reset_i == init_i)
        else begin
            $error("FIFO reset outputs do not follow init_i");
            fail_cnt++;
        end

    for (genvar i = 0; i < FIFO_PER_KIND; i++) begin : g_entry
        a_clear: assert property (@(posedge clk)
            $rose(rst_n) |-> ifmap_addr_i[i] == '0 && ipsum_addr_i[i] == '0
            && opsum_addr_i[i] == '0)
            else begin
                $error("entry %0d is not cleared after reset", i);
                fail_cnt++;
            end

        a_ifmap_load: assert property (@(posedge clk) disable iff (!rst_n)
            $past(init_i) |-> ifmap_addr_i[i] == ifmap_rule(i, $past(layer_type_i),
                $past(ifmap_base_i), $past(tile_n_i), $past(in_c_i),
                $past(output_row_i), $past(tile_first_i), $past(ifmap_addr_i[i])))
            else begin
                $error("ifmap entry %0d does not follow its address rule", i);
                fail_cnt++;
            end

        a_ipsum_load: assert property (@(posedge clk) disable iff (!rst_n)
            $past(init_i) |-> ipsum_addr_i[i] == psum_rule(i, $past(layer_type_i),
                $past(ipsum_base_i), $past(on_real_i), $past(out_c_i),
                $past(output_row_i), $past(ipsum_addr_i[i])))
            else begin
                $error("ipsum entry %0d does not follow its address rule", i);
                fail_cnt++;
            end

        a_opsum_load: assert property (@(posedge clk) disable iff (!rst_n)
            $past(init_i) |-> opsum_addr_i[i] == psum_rule(i, $past(layer_type_i),
                $past(opsum_base_i), $past(on_real_i), $past(out_c_i),
                $past(output_row_i), $past(opsum_addr_i[i])))
            else begin
                $error("opsum entry %0d does not follow its address rule", i);
                fail_cnt++;
            end

        // no load, no change
        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            !$past(init_i) |-> $stable(ifmap_addr_i[i]) && $stable(ipsum_addr_i[i])
            && $stable(opsum_addr_i[i]))
            else begin
                $error("entry %0d changed while init_i was low", i);
                fail_cnt++;
            end
    end

endmodule

bind l2c_init_fifo_pe l2c_init_checker u_checker (
    .clk                (clk),
    .rst_n              (rst_n),
    .init_i             (init_i),
    .layer_type_i       (layer_type_i),
    .ifmap_base_i       (ifmap_base_i),
    .ipsum_base_i       (ipsum_base_i),
    .opsum_base_i       (opsum_base_i),
    .tile_n_i           (tile_n_i),
    .on_real_i          (on_real_i),
    .in_c_i             (in_c_i),
    .out_c_i            (out_c_i),
    .output_row_i       (output_row_i),
    .tile_first_i       (tile_first_i),
    .ifmap_addr_i       (ifmap_addr_o),
    .ipsum_addr_i       (ipsum_addr_o),
    .opsum_addr_i       (opsum_addr_o),
    .ifmap_fifo_reset_i (ifmap_fifo_reset_o),
    .ipsum_fifo_reset_i (ipsum_fifo_reset_o),
    .opsum_fifo_reset_i (opsum_fifo_reset_o)
);

/* test/tb_l2c_init.sv */
// ------------------------------------------------
// stimulus only, the bound checker judges every load and hold
// a test passes when it raises no assertion failure
// ------------------------------------------------
module tb_l2c_init import l2c_pkg::*; ();

    localparam int unsigned SEED       = 32'h72e9_07c0;
    localparam int          WAIT_LIMIT = 4;   // 1-unit steps, well inside one cycle

    logic            clk;
    logic            rst_n;
    logic            init;
    layer_type_e     layer_type;
    addr_t           ifmap_base;
    addr_t           ipsum_base;
    addr_t           opsum_base;
    addr_t           tile_n;
    addr_t           on_real;
    logic [CH_W-1:0] in_c;
    logic [CH_W-1:0] out_c;
    addr_t           output_row;
    logic            tile_first;
    addr_t           ifmap_addr [FIFO_PER_KIND];
    addr_t           ipsum_addr [FIFO_PER_KIND];
    addr_t           opsum_addr [FIFO_PER_KIND];
    logic            ifmap_rst;
    logic            ipsum_rst;
    logic            opsum_rst;

    int              tests_run;
    int              tests_failed;
    int unsigned     fails_at_start;
    bit              reset_timeout;   // reset outputs lagged init in this test

    l2c_init_fifo_pe DUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .init_i             (init),
        .layer_type_i       (layer_type),
        .ifmap_base_i       (ifmap_base),
        .ipsum_base_i       (ipsum_base),
        .opsum_base_i       (opsum_base),
        .tile_n_i           (tile_n),
        .on_real_i          (on_real),
        .in_c_i             (in_c),
        .out_c_i            (out_c),
        .output_row_i       (output_row),
        .tile_first_i       (tile_first),
        .ifmap_addr_o       (ifmap_addr),
        .ipsum_addr_o       (ipsum_addr),
        .opsum_addr_o       (opsum_addr),
        .ifmap_fifo_reset_o (ifmap_rst),
        .ipsum_fifo_reset_o (ipsum_rst),
        .opsum_fifo_reset_o (opsum_rst)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;  // drive just after the edge
    endtask

    function automatic bit resets_at(input logic level);
        return ifmap_rst == level && ipsum_rst == level && opsum_rst == level;
    endfunction

    task automatic wait_resets(input logic level);
        int tries;
        tries = 0;
        while (tries < WAIT_LIMIT && !resets_at(level)) begin
            #1;
            tries++;
        end
        if (!resets_at(level)) begin
            $display("timeout: FIFO reset outputs did not follow init_i");
            reset_timeout = 1'b1;
        end
    endtask

    // hold init for n edges, each edge is one load
    task automatic load(input int n);
        init = 1'b1;
        wait_resets(1'b1);
        repeat (n) step();
        init = 1'b0;
        wait_resets(1'b0);
    endtask

    task automatic random_sizes();
        ifmap_base = $urandom;
        ipsum_base = $urandom;
        opsum_base = $urandom;
        tile_n     = addr_t'($urandom_range(64, 1));
        on_real    = addr_t'($urandom_range(32, 1));
        in_c       = CH_W'($urandom_range(255, 1));
        out_c      = CH_W'($urandom_range(255, 1));
        output_row = addr_t'($urandom_range(15, 0));
    endtask

    task automatic start_test();
        fails_at_start = DUT.u_checker.fail_cnt;
        reset_timeout  = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int unsigned new_fails;
        new_fails = DUT.u_checker.fail_cnt - fails_at_start;
        tests_run++;
        if (new_fails == 0 && !reset_timeout) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            if (new_fails != 0) begin
                $display("error: test %s expected 0 assertion failures, actual %0d",
                         name, new_fails);
            end
            if (reset_timeout) begin
                $display("test %s failed, FIFO reset outputs timed out", name);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n          = 1'b1;
        init           = 1'b0;
        layer_type     = POINTWISE;
        ifmap_base     = '0;
        ipsum_base     = '0;
        opsum_base     = '0;
        tile_n         = '0;
        on_real        = '0;
        in_c           = '0;
        out_c          = '0;
        output_row     = '0;
        tile_first     = 1'b0;
        tests_run      = 0;
        tests_failed   = 0;
        fails_at_start = 0;
        reset_timeout  = 1'b0;
        #1 rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        start_test();
        step();
        step();
        finish_test("reset");

        start_test();
        random_sizes();
        layer_type = POINTWISE;
        load(1);
        step();
        finish_test("pointwise");

        start_test();
        random_sizes();
        layer_type = DEPTHWISE;
        tile_first = 1'b1;
        output_row = '0;       // top pad row
        load(1);
        output_row = 32'd1;
        load(1);
        step();
        finish_test("depthwise_first_tile");

        start_test();
        random_sizes();
        layer_type = POINTWISE;   // fills entries 30 and 31
        load(1);
        layer_type = DEPTHWISE;
        tile_first = 1'b0;
        output_row = '0;
        load(1);
        output_row = 32'd2;
        load(3);                  // three advances
        step();
        finish_test("depthwise_slide");

        start_test();
        random_sizes();
        layer_type = POINTWISE;
        load(1);
        random_sizes();
        layer_type = STANDARD;
        load(1);
        random_sizes();
        layer_type = DEPTHWISE;
        tile_first = 1'b0;
        load(1);
        random_sizes();
        layer_type = LINEAR;
        load(2);
        step();
        finish_test("spatial_psum");

        start_test();
        repeat (5) begin
            random_sizes();
            layer_type = layer_type_e'(2'($urandom_range(3, 0)));
            tile_first = 1'($urandom_range(1, 0));
            step();
        end
        finish_test("hold");

        $display("tests run %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, DUT.u_checker.fail_cnt);
        if (tests_failed == 0 && DUT.u_checker.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
hw/l2c_pkg.sv
hw/ifmap_addr_gen.sv
hw/psum_addr_gen.sv
hw/l2c_init_fifo_pe.sv
test/l2c_init_checker.sv
test/tb_l2c_init.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_l2c_init
FILELIST  := project.f
BUILD     := obj_dir
FLAGS     := --binary --timing --assert -j 0
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
